// File: eth_lfc_settings.svh
// Width, PAUSE frame layout and pause quanta timing macros for the flow control layer
`ifndef ETH_LFC_SETTINGS_SVH
`define ETH_LFC_SETTINGS_SVH

// Stream geometry
`define ETH_DATA_W 64
`define ETH_KEEP_W 8

// Generated MAC control frame, 60 bytes before FCS
`define MCF_BEATS 8
`define MCF_LAST_KEEP 8'h0f
`define MCF_DST_MCAST 48'h01_80_C2_00_00_01
`define MCF_ETH_TYPE 16'h8808

// One quantum is 512 bit times, 64 bits per clock
`define QUANTA_CYCLES 8
`define QUANTA_W 16

`endif

// File: eth_lfc_pkg.sv
// Shared beat, address and quanta types with the arbiter state, header position and opcode enums
`default_nettype none

`include "eth_lfc_settings.svh"

package eth_lfc_pkg;

    typedef logic [`ETH_DATA_W-1:0] data_t;
    typedef logic [`ETH_KEEP_W-1:0] keep_t;
    typedef logic [47:0]            mac_addr_t;
    typedef logic [`QUANTA_W-1:0]   quanta_t;

    // 802.3 annex 31B opcode, other values pass through as raw codes
    typedef enum logic [15:0] {
        MCF_OP_PAUSE = 16'h0001
    } mcf_opcode_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DATA,
        TX_MCF
    } tx_ctrl_state_e;

    typedef enum logic [1:0] {
        RX_HDR0,  // Destination and first source bytes
        RX_HDR1,  // Source tail, EtherType, opcode
        RX_HDR2,  // Pause quanta
        RX_BODY
    } rx_beat_e;

endpackage

`default_nettype wire

// File: mac_ctrl_tx.sv
// Transmit arbiter that inserts PAUSE frames between application frames and halts data on pause
`default_nettype none

`include "eth_lfc_settings.svh"

module mac_ctrl_tx import eth_lfc_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire data_t     app_tx_tdata,
    input  wire keep_t     app_tx_tkeep,
    input  wire logic      app_tx_tvalid,
    output logic           app_tx_tready,
    input  wire logic      app_tx_tlast,
    output data_t          mac_tx_tdata,
    output keep_t          mac_tx_tkeep,
    output logic           mac_tx_tvalid,
    input  wire logic      mac_tx_tready,
    output logic           mac_tx_tlast,
    input  wire logic      mcf_valid,
    output logic           mcf_ready,
    input  wire mac_addr_t mcf_src,
    input  wire quanta_t   mcf_quanta,
    input  wire logic      tx_pause_req,
    output logic           tx_pause_ack,
    output logic           stat_tx_mcf
);

    localparam int          BEAT_W = $clog2(`MCF_BEATS) + 1;
    localparam mac_addr_t   DST    = `MCF_DST_MCAST;
    localparam logic [15:0] ETYPE  = `MCF_ETH_TYPE;
    localparam logic [15:0] OPCODE = MCF_OP_PAUSE;

    tx_ctrl_state_e    state;
    logic [BEAT_W-1:0] mcf_beat;
    mac_addr_t         src_q;
    quanta_t           quanta_q;
    data_t             mcf_data;
    logic              data_grant;
    logic              data_fire;
    logic              mcf_fire;
    logic              mcf_last;

    // Data may pass in idle only with nothing else pending
    assign data_grant   = (state == TX_DATA) ||
                          ((state == TX_IDLE) && !mcf_valid && !tx_pause_req);
    assign mcf_ready    = (state == TX_IDLE) && mcf_valid;  // Control frame wins over data
    assign tx_pause_ack = (state == TX_IDLE) && tx_pause_req;
    assign mcf_last     = mcf_beat == BEAT_W'(`MCF_BEATS - 1);
    assign mcf_fire     = (state == TX_MCF) && mac_tx_tready;
    assign data_fire    = (state != TX_MCF) && mac_tx_tvalid && mac_tx_tready;
    assign stat_tx_mcf  = mcf_fire && mcf_last;

    // Network byte order, byte 0 in the low lane
    always_comb begin
        mcf_data = '0;
        case (mcf_beat)
            0: mcf_data = {src_q[39:32], src_q[47:40], DST[7:0], DST[15:8],
                           DST[23:16], DST[31:24], DST[39:32], DST[47:40]};
            1: mcf_data = {OPCODE[7:0], OPCODE[15:8], ETYPE[7:0], ETYPE[15:8],
                           src_q[7:0], src_q[15:8], src_q[23:16], src_q[31:24]};
            2: mcf_data = {48'd0, quanta_q[7:0], quanta_q[15:8]};
            default: mcf_data = '0;  // Zero padding up to 60 bytes
        endcase
    end

    always_comb begin
        if (state == TX_MCF) begin
            mac_tx_tdata  = mcf_data;
            mac_tx_tkeep  = mcf_last ? keep_t'(`MCF_LAST_KEEP) : '1;
            mac_tx_tvalid = 1'b1;
            mac_tx_tlast  = mcf_last;
            app_tx_tready = 1'b0;
        end else begin
            mac_tx_tdata  = app_tx_tdata;
            mac_tx_tkeep  = app_tx_tkeep;
            mac_tx_tvalid = app_tx_tvalid && data_grant;
            mac_tx_tlast  = app_tx_tlast;
            app_tx_tready = mac_tx_tready && data_grant;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= TX_IDLE;
            mcf_beat <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (mcf_ready) begin
                        state <= TX_MCF;
                    end else if (data_grant && app_tx_tvalid && !(data_fire && app_tx_tlast)) begin
                        state <= TX_DATA;  // Frame is committed once offered
                    end
                end
                TX_DATA: begin
                    if (data_fire && app_tx_tlast) begin
                        state <= TX_IDLE;
                    end
                end
                TX_MCF: begin
                    if (mcf_fire) begin
                        mcf_beat <= mcf_last ? '0 : mcf_beat + 1'b1;
                        if (mcf_last) begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mcf_ready) begin
            src_q    <= mcf_src;
            quanta_q <= mcf_quanta;
        end
    end

    // No application beat may slip in while a control frame is in progress
    a_grant_excl: assert property (@(posedge clk) disable iff (!arst_n)
        mcf_ready |=> !app_tx_tready [*`MCF_BEATS]);

    a_beat_max: assert property (@(posedge clk) disable iff (!arst_n)
        (state == TX_MCF) |-> mcf_beat < BEAT_W'(`MCF_BEATS));

endmodule

`default_nettype wire

// File: mac_pause_ctrl_tx.sv
// PAUSE frame scheduler issuing XOFF, refresh and XON requests to the transmit arbiter
`default_nettype none

`include "eth_lfc_settings.svh"

module mac_pause_ctrl_tx import eth_lfc_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      tx_lfc_req,
    input  wire logic      tx_lfc_resend,
    input  wire logic      cfg_tx_lfc_en,
    input  wire mac_addr_t cfg_tx_lfc_src,
    input  wire quanta_t   cfg_tx_lfc_quanta,
    input  wire quanta_t   cfg_tx_lfc_refresh,
    input  wire logic      mcf_ready,
    output logic           mcf_valid,
    output mac_addr_t      mcf_src,
    output quanta_t        mcf_quanta
);

    localparam int CNT_W = `QUANTA_W + 3;

    logic             req_q;
    logic             refresh_active;
    logic [CNT_W-1:0] refresh_cnt;
    logic             refresh_expire;
    logic             xoff_req;
    logic             xon_req;

    assign refresh_expire = refresh_active && (refresh_cnt == '0) && tx_lfc_req;

    assign xoff_req = cfg_tx_lfc_en &&
                      ((tx_lfc_req && !req_q) || refresh_expire || (tx_lfc_resend && tx_lfc_req));
    assign xon_req  = cfg_tx_lfc_en &&
                      ((!tx_lfc_req && req_q) || (tx_lfc_resend && !tx_lfc_req));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q          <= 1'b0;
            mcf_valid      <= 1'b0;
            refresh_active <= 1'b0;
            refresh_cnt    <= '0;
        end else begin
            req_q <= tx_lfc_req;  // Edge detect

            // A new request while pending just overwrites the fields
            if (xoff_req || xon_req) begin
                mcf_valid <= 1'b1;
            end else if (mcf_ready) begin
                mcf_valid <= 1'b0;
            end

            if (mcf_ready) begin
                refresh_cnt    <= CNT_W'(cfg_tx_lfc_refresh) * CNT_W'(`QUANTA_CYCLES);
                refresh_active <= tx_lfc_req;  // Refresh only follows an XOFF
            end else if (!tx_lfc_req || refresh_expire) begin
                refresh_active <= 1'b0;
            end else if (refresh_active) begin
                refresh_cnt <= refresh_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xoff_req || xon_req) begin
            mcf_src    <= cfg_tx_lfc_src;
            mcf_quanta <= xoff_req ? cfg_tx_lfc_quanta : '0;  // Zero quanta is XON
        end
    end

endmodule

`default_nettype wire

// File: mac_ctrl_rx.sv
// Receive control frame detector with a two-stage delay line that drops control frames
`default_nettype none

`include "eth_lfc_settings.svh"

module mac_ctrl_rx import eth_lfc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire data_t mac_rx_tdata,
    input  wire keep_t mac_rx_tkeep,
    input  wire logic  mac_rx_tvalid,
    input  wire logic  mac_rx_tlast,
    input  wire logic  mac_rx_tuser,
    output data_t      app_rx_tdata,
    output keep_t      app_rx_tkeep,
    output logic       app_rx_tvalid,
    output logic       app_rx_tlast,
    output logic       app_rx_tuser,
    output logic       rx_mcf_valid,
    output mcf_opcode_e rx_mcf_opcode,
    output quanta_t    rx_mcf_quanta,
    output logic       stat_rx_mcf
);

    localparam mac_addr_t   DST   = `MCF_DST_MCAST;
    localparam logic [15:0] ETYPE = `MCF_ETH_TYPE;

    rx_beat_e beat;
    logic     dst_match;
    logic     frame_mcf;
    logic     hdr_is_mcf;
    logic     mark_in;
    data_t    s1_data;
    keep_t    s1_keep;
    logic     s1_valid;
    logic     s1_last;
    logic     s1_user;
    logic     s1_mark;
    logic     s2_valid;
    logic     s2_mark;

    // EtherType sits in bytes 12 and 13 of the second beat
    assign hdr_is_mcf = dst_match && ({mac_rx_tdata[39:32], mac_rx_tdata[47:40]} == ETYPE);

    always_comb begin
        case (beat)
            RX_HDR0: mark_in = 1'b0;  // Not known until the next beat
            RX_HDR1: mark_in = hdr_is_mcf;
            default: mark_in = frame_mcf;
        endcase
    end

    assign app_rx_tvalid = s2_valid && !s2_mark;
    assign stat_rx_mcf   = rx_mcf_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat         <= RX_HDR0;
            dst_match    <= 1'b0;
            frame_mcf    <= 1'b0;
            s1_valid     <= 1'b0;
            s1_mark      <= 1'b0;
            s2_valid     <= 1'b0;
            s2_mark      <= 1'b0;
            rx_mcf_valid <= 1'b0;
        end else begin
            s1_valid <= mac_rx_tvalid;
            s1_mark  <= mac_rx_tvalid && mark_in;
            s2_valid <= s1_valid;
            // Header beat still in stage 1 picks up the late decision
            s2_mark  <= (mac_rx_tvalid && beat == RX_HDR1) ? hdr_is_mcf : s1_mark;

            rx_mcf_valid <= mac_rx_tvalid && mac_rx_tlast && !mac_rx_tuser && mark_in;

            if (mac_rx_tvalid) begin
                case (beat)
                    RX_HDR0: begin
                        dst_match <= {mac_rx_tdata[7:0], mac_rx_tdata[15:8],
                                      mac_rx_tdata[23:16], mac_rx_tdata[31:24],
                                      mac_rx_tdata[39:32], mac_rx_tdata[47:40]} == DST;
                        beat <= RX_HDR1;
                    end
                    RX_HDR1: begin
                        frame_mcf <= hdr_is_mcf;
                        beat      <= RX_HDR2;
                    end
                    default: beat <= RX_BODY;
                endcase
                if (mac_rx_tlast) begin
                    beat <= RX_HDR0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_data      <= mac_rx_tdata;
        s1_keep      <= mac_rx_tkeep;
        s1_last      <= mac_rx_tlast;
        s1_user      <= mac_rx_tuser;
        app_rx_tdata <= s1_data;
        app_rx_tkeep <= s1_keep;
        app_rx_tlast <= s1_last;
        app_rx_tuser <= s1_user;
        if (mac_rx_tvalid && beat == RX_HDR1) begin
            rx_mcf_opcode <= mcf_opcode_e'({mac_rx_tdata[55:48], mac_rx_tdata[63:56]});
        end
        if (mac_rx_tvalid && beat == RX_HDR2) begin
            rx_mcf_quanta <= {mac_rx_tdata[7:0], mac_rx_tdata[15:8]};
        end
    end

    // The header tracker relies on gap-free beats inside a frame
    a_rx_contig: assert property (@(posedge clk) disable iff (!arst_n)
        (mac_rx_tvalid && !mac_rx_tlast) |=> mac_rx_tvalid);

endmodule

`default_nettype wire

// File: mac_pause_ctrl_rx.sv
// Receive pause quanta timer that holds the pause request level
`default_nettype none

`include "eth_lfc_settings.svh"

module mac_pause_ctrl_rx import eth_lfc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        rx_mcf_valid,
    input  wire mcf_opcode_e rx_mcf_opcode,
    input  wire quanta_t     rx_mcf_quanta,
    input  wire logic        cfg_rx_lfc_en,
    input  wire logic        rx_lfc_en,
    input  wire logic        rx_lfc_ack,
    output logic             rx_lfc_req
);

    localparam int CNT_W = `QUANTA_W + 3;

    logic             pause_hit;
    logic [CNT_W-1:0] pause_cnt;

    assign pause_hit = rx_mcf_valid && (rx_mcf_opcode == MCF_OP_PAUSE) &&
                       cfg_rx_lfc_en && rx_lfc_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_lfc_req <= 1'b0;
            pause_cnt  <= '0;
        end else if (pause_hit) begin
            // New frame reloads, quanta 0 releases at once
            pause_cnt  <= CNT_W'(rx_mcf_quanta) * CNT_W'(`QUANTA_CYCLES);
            rx_lfc_req <= rx_mcf_quanta != '0;
        end else if (rx_lfc_req && rx_lfc_ack) begin
            pause_cnt <= pause_cnt - 1'b1;
            if (pause_cnt == CNT_W'(1)) begin
                rx_lfc_req <= 1'b0;  // Last quantum cycle spent
            end
        end
    end

    // An expired count only leaves zero through a reload
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        ((pause_cnt == '0) && !pause_hit) |=> (pause_cnt == '0));

endmodule

`default_nettype wire

// File: eth_mac_lfc.sv
// Flow control top joining the transmit and receive control blocks with the pause coupling
`default_nettype none

module eth_mac_lfc import eth_lfc_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire data_t     app_tx_tdata,
    input  wire keep_t     app_tx_tkeep,
    input  wire logic      app_tx_tvalid,
    output wire logic      app_tx_tready,
    input  wire logic      app_tx_tlast,
    output wire data_t     mac_tx_tdata,
    output wire keep_t     mac_tx_tkeep,
    output wire logic      mac_tx_tvalid,
    input  wire logic      mac_tx_tready,
    output wire logic      mac_tx_tlast,
    input  wire data_t     mac_rx_tdata,
    input  wire keep_t     mac_rx_tkeep,
    input  wire logic      mac_rx_tvalid,
    input  wire logic      mac_rx_tlast,
    input  wire logic      mac_rx_tuser,
    output wire data_t     app_rx_tdata,
    output wire keep_t     app_rx_tkeep,
    output wire logic      app_rx_tvalid,
    output wire logic      app_rx_tlast,
    output wire logic      app_rx_tuser,
    input  wire logic      tx_lfc_req,
    input  wire logic      tx_lfc_resend,
    input  wire logic      rx_lfc_en,
    output wire logic      rx_lfc_req,
    input  wire logic      rx_lfc_ack,
    input  wire logic      tx_lfc_pause_en,
    input  wire logic      tx_pause_req,
    output wire logic      tx_pause_ack,
    input  wire logic      cfg_tx_lfc_en,
    input  wire mac_addr_t cfg_tx_lfc_src,
    input  wire quanta_t   cfg_tx_lfc_quanta,
    input  wire quanta_t   cfg_tx_lfc_refresh,
    input  wire logic      cfg_rx_lfc_en,
    output wire logic      stat_tx_mcf,
    output wire logic      stat_rx_mcf
);

    wire logic        mcf_valid;
    wire logic        mcf_ready;
    wire mac_addr_t   mcf_src;
    wire quanta_t     mcf_quanta;
    wire logic        rx_mcf_valid;
    wire mcf_opcode_e rx_mcf_opcode;
    wire quanta_t     rx_mcf_quanta;
    wire logic        tx_pause_req_int;
    wire logic        rx_lfc_ack_int;

    // Received PAUSE halts the local transmitter when enabled
    assign tx_pause_req_int = tx_pause_req || (tx_lfc_pause_en && rx_lfc_req);
    // Pause time only elapses while the transmitter is really halted
    assign rx_lfc_ack_int   = rx_lfc_ack || (tx_lfc_pause_en && tx_pause_ack);

    mac_ctrl_tx mac_ctrl_tx_i (.*, .tx_pause_req(tx_pause_req_int));

    mac_pause_ctrl_tx mac_pause_ctrl_tx_i (.*);

    mac_ctrl_rx mac_ctrl_rx_i (.*);

    mac_pause_ctrl_rx mac_pause_ctrl_rx_i (.*, .rx_lfc_ack(rx_lfc_ack_int));

endmodule

`default_nettype wire

// File: tb_eth_mac_lfc.sv
// Directed testbench for the flow control layer with clock, reset, LFSR, checks and five tests
`default_nettype none

`include "eth_lfc_settings.svh"

module tb_eth_mac_lfc import eth_lfc_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam mac_addr_t DST        = `MCF_DST_MCAST;
    localparam mac_addr_t CFG_SRC    = 48'h02_11_22_33_44_55;
    localparam mac_addr_t PEER_SRC   = 48'h02_aa_bb_cc_dd_ee;
    localparam quanta_t   CFG_QUANTA = 16'h0010;
    localparam quanta_t   CFG_REFR   = 16'd4;
    localparam int        BUDGET     = 16 + 800 + 300 + 300 + 1300 + 700;  // Cycles over all tests

    logic clk = 1'b0;
    logic arst_n;
    data_t app_tx_tdata, mac_tx_tdata, mac_rx_tdata, app_rx_tdata;
    keep_t app_tx_tkeep, mac_tx_tkeep, mac_rx_tkeep, app_rx_tkeep;
    logic app_tx_tvalid, app_tx_tready, app_tx_tlast;
    logic mac_tx_tvalid, mac_tx_tready, mac_tx_tlast;
    logic mac_rx_tvalid, mac_rx_tlast, mac_rx_tuser;
    logic app_rx_tvalid, app_rx_tlast, app_rx_tuser;
    logic tx_lfc_req, tx_lfc_resend, rx_lfc_en, rx_lfc_req, rx_lfc_ack;
    logic tx_lfc_pause_en, tx_pause_req, tx_pause_ack;
    logic cfg_tx_lfc_en, cfg_rx_lfc_en, stat_tx_mcf, stat_rx_mcf;
    mac_addr_t cfg_tx_lfc_src;
    quanta_t   cfg_tx_lfc_quanta, cfg_tx_lfc_refresh;

    logic [31:0] lfsr_state = 32'h7c54;
    logic        stall_en = 1'b0;
    int          cyc = 0;
    int          rx_mcf_cnt = 0, stat_rx_cnt = 0, stat_tx_cnt = 0;
    int          rise_cyc = 0, fall_cyc = 0;
    logic        req_prev = 1'b0;
    logic        ack_seen = 1'b0;

    // Observed and expected beats
    data_t tx_data_q[$], exp_data_q[$], rx_data_q[$], exp_rx_q[$];
    keep_t tx_keep_q[$], exp_keep_q[$], rx_keep_q[$], exp_rx_keep_q[$];
    logic  tx_last_q[$], exp_last_q[$], rx_last_q[$], exp_rx_last_q[$];
    logic  rx_user_q[$], exp_rx_user_q[$];
    int    tx_cyc_q[$], rx_cyc_q[$], exp_rx_cyc_q[$];

    eth_mac_lfc dut_i (.*);

    always #5 clk = ~clk;

    // Monitors sample on the rising edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (mac_tx_tvalid && mac_tx_tready) begin
            tx_data_q.push_back(mac_tx_tdata);
            tx_keep_q.push_back(mac_tx_tkeep);
            tx_last_q.push_back(mac_tx_tlast);
            tx_cyc_q.push_back(cyc);
        end
        if (app_rx_tvalid) begin
            rx_data_q.push_back(app_rx_tdata);
            rx_keep_q.push_back(app_rx_tkeep);
            rx_last_q.push_back(app_rx_tlast);
            rx_user_q.push_back(app_rx_tuser);
            rx_cyc_q.push_back(cyc);
        end
        if (dut_i.rx_mcf_valid) rx_mcf_cnt++;
        if (stat_rx_mcf) stat_rx_cnt++;
        if (stat_tx_mcf) stat_tx_cnt++;
        if (tx_pause_ack) ack_seen = 1'b1;
        if (rx_lfc_req && !req_prev) rise_cyc = cyc;
        if (!rx_lfc_req && req_prev) fall_cyc = cyc;
        req_prev = rx_lfc_req;
    end

    initial begin
        #(BUDGET * 10);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[62:0], lfsr_step()};
        return r;
    endfunction

    // PAUSE frame byte i in wire order
    function automatic logic [7:0] pause_byte(int i, mac_addr_t src, quanta_t q);
        if (i < 6) return DST[47-8*i -: 8];
        if (i < 12) return src[47-8*(i-6) -: 8];
        case (i)
            12: return 8'h88;
            13: return 8'h08;
            14: return 8'h00;
            15: return 8'h01;
            16: return q[15:8];
            17: return q[7:0];
            default: return 8'h00;
        endcase
    endfunction

    function automatic data_t pause_beat(int b, mac_addr_t src, quanta_t q);
        data_t d;
        for (int j = 0; j < 8; j++) d[8*j +: 8] = pause_byte(8*b + j, src, q);
        return d;
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic send_tx_frame(int n);
        int tries;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            app_tx_tvalid = 1'b1;
            app_tx_tdata  = rand_bits(64);
            app_tx_tkeep  = (i == n - 1) ? 8'h3f : 8'hff;
            app_tx_tlast  = (i == n - 1);
            exp_data_q.push_back(app_tx_tdata);
            exp_keep_q.push_back(app_tx_tkeep);
            exp_last_q.push_back(app_tx_tlast);
            tries = 0;
            forever begin
                if (stall_en) mac_tx_tready = lfsr_step() | lfsr_step();
                @(posedge clk);
                if (app_tx_tready) break;
                tries++;
                if (tries > 300) abort_run("Application beat was never accepted");
                @(negedge clk);
            end
        end
        @(negedge clk);
        app_tx_tvalid = 1'b0;
        app_tx_tlast  = 1'b0;
        mac_tx_tready = 1'b1;
    endtask

    task automatic wait_tx_beats(int n);
        int t;
        t = 0;
        while (tx_data_q.size() < n) begin
            @(posedge clk);
            t++;
            if (t > 400) abort_run("Expected beats never came out on mac_tx");
        end
    endtask

    task automatic compare_app_beat(string name, output int stamp);
        wait_tx_beats(1);
        check_eq({name, " data"}, exp_data_q.pop_front(), tx_data_q.pop_front());
        check_eq({name, " keep"}, exp_keep_q.pop_front(), tx_keep_q.pop_front());
        check_eq({name, " last"}, exp_last_q.pop_front(), tx_last_q.pop_front());
        stamp = tx_cyc_q.pop_front();
    endtask

    task automatic expect_pause_frame(string name, quanta_t q, output int start);
        wait_tx_beats(`MCF_BEATS);
        start = tx_cyc_q[0];
        for (int b = 0; b < `MCF_BEATS; b++) begin
            check_eq({name, " data"}, pause_beat(b, CFG_SRC, q), tx_data_q.pop_front());
            check_eq({name, " keep"}, (b == `MCF_BEATS - 1) ? `MCF_LAST_KEEP : 8'hff,
                     tx_keep_q.pop_front());
            check_eq({name, " last"}, b == `MCF_BEATS - 1, tx_last_q.pop_front());
            void'(tx_cyc_q.pop_front());
        end
    endtask

    task automatic send_rx_beat(data_t d, keep_t k, logic last, logic user, logic keep_it);
        @(negedge clk);
        mac_rx_tvalid = 1'b1;
        mac_rx_tdata  = d;
        mac_rx_tkeep  = k;
        mac_rx_tlast  = last;
        mac_rx_tuser  = user;
        @(posedge clk);
        if (keep_it) begin
            exp_rx_q.push_back(d);
            exp_rx_keep_q.push_back(k);
            exp_rx_last_q.push_back(last);
            exp_rx_user_q.push_back(user);
            exp_rx_cyc_q.push_back(cyc + 2);
        end
    endtask

    task automatic send_rx_data(int n, logic bad);
        data_t d;
        for (int i = 0; i < n; i++) begin
            d = rand_bits(64);
            if (i == 0) d[7:0] = 8'h02;  // Unicast destination
            send_rx_beat(d, (i == n - 1) ? 8'h7f : 8'hff, i == n - 1,
                         bad && (i == n - 1), 1'b1);
        end
    endtask

    task automatic send_rx_pause(quanta_t q, logic user);
        for (int b = 0; b < `MCF_BEATS; b++)
            send_rx_beat(pause_beat(b, PEER_SRC, q), (b == `MCF_BEATS - 1) ? `MCF_LAST_KEEP : 8'hff,
                         b == `MCF_BEATS - 1, user, 1'b0);
    endtask

    task automatic rx_idle();
        @(negedge clk);
        mac_rx_tvalid = 1'b0;
        mac_rx_tlast  = 1'b0;
        mac_rx_tuser  = 1'b0;
    endtask

    task automatic wait_rx_req_rise();
        int t;
        t = 0;
        while (!rx_lfc_req) begin
            @(posedge clk);
            t++;
            if (t > 100) abort_run("rx_lfc_req never rose after a PAUSE frame");
        end
    endtask

    task automatic test_tx_passthrough();
        int stamp;
        stall_en = 1'b1;
        for (int f = 0; f < 6; f++) send_tx_frame(1 + int'(rand_bits(3)));
        stall_en = 1'b0;
        while (exp_data_q.size() > 0) compare_app_beat("tx_passthrough", stamp);
    endtask

    task automatic test_rx_filter();
        int mcf0, stat0;
        mcf0  = rx_mcf_cnt;
        stat0 = stat_rx_cnt;
        send_rx_data(3, 1'b0);
        send_rx_pause(16'd0, 1'b0);
        send_rx_data(2, 1'b1);
        send_rx_pause(16'd0, 1'b1);
        send_rx_pause(16'd0, 1'b0);
        send_rx_data(4, 1'b0);
        rx_idle();
        repeat (6) @(posedge clk);
        check_eq("rx_filter beats", exp_rx_q.size(), rx_data_q.size());
        while (exp_rx_q.size() > 0) begin
            check_eq("rx_filter data", exp_rx_q.pop_front(), rx_data_q.pop_front());
            check_eq("rx_filter keep", exp_rx_keep_q.pop_front(), rx_keep_q.pop_front());
            check_eq("rx_filter last", exp_rx_last_q.pop_front(), rx_last_q.pop_front());
            check_eq("rx_filter user", exp_rx_user_q.pop_front(), rx_user_q.pop_front());
            check_eq("rx_filter cycle", exp_rx_cyc_q.pop_front(), rx_cyc_q.pop_front());
        end
        check_eq("rx_filter mcf pulses", 2, rx_mcf_cnt - mcf0);
        check_eq("rx_filter stat pulses", 2, stat_rx_cnt - stat0);
    endtask

    task automatic test_pause_gen();
        int s1, s2, s3, stat0;
        stat0 = stat_tx_cnt;
        @(negedge clk);
        tx_lfc_req = 1'b1;
        expect_pause_frame("pause_gen xoff", CFG_QUANTA, s1);
        expect_pause_frame("pause_gen refresh", CFG_QUANTA, s2);
        if (s2 - s1 < CFG_REFR * `QUANTA_CYCLES)
            abort_run("Refresh PAUSE frame came too early");
        if (s2 - s1 > CFG_REFR * `QUANTA_CYCLES + `MCF_BEATS)
            abort_run("Refresh PAUSE frame came too late");
        @(negedge clk);
        tx_lfc_req = 1'b0;
        expect_pause_frame("pause_gen xon", 16'd0, s3);
        repeat (50) @(posedge clk);
        check_eq("pause_gen extra beats", 0, tx_data_q.size());
        check_eq("pause_gen stat pulses", 3, stat_tx_cnt - stat0);
    endtask

    task automatic test_rx_timer();
        int n;
        @(negedge clk);
        rx_lfc_ack = 1'b1;
        send_rx_pause(16'd5, 1'b0);
        rx_idle();
        wait_rx_req_rise();
        n = 0;
        while (rx_lfc_req) begin
            n++;
            @(posedge clk);
        end
        check_eq("rx_timer length", 5 * `QUANTA_CYCLES, n);
        send_rx_pause(16'd100, 1'b0);
        rx_idle();
        wait_rx_req_rise();
        repeat (10) @(posedge clk);
        send_rx_pause(16'd0, 1'b0);
        rx_idle();
        @(posedge clk);
        check_eq("rx_timer held", 1, rx_lfc_req);
        @(posedge clk);
        check_eq("rx_timer early drop", 0, rx_lfc_req);
        @(negedge clk);
        cfg_rx_lfc_en = 1'b0;
        send_rx_pause(16'd5, 1'b0);
        rx_idle();
        repeat (60) begin
            @(posedge clk);
            check_eq("rx_timer disabled", 0, rx_lfc_req);
        end
        @(negedge clk);
        cfg_rx_lfc_en = 1'b1;
        rx_lfc_ack    = 1'b0;
    endtask

    task automatic test_pause_coupling();
        int stamp, last_a, s_off, s_on;
        @(negedge clk);
        tx_lfc_pause_en = 1'b1;
        ack_seen = 1'b0;
        fork
            begin
                send_tx_frame(20);
                send_tx_frame(3);
            end
            begin
                repeat (3) @(negedge clk);
                send_rx_pause(16'd6, 1'b0);
                rx_idle();
                wait_rx_req_rise();
                wait_tx_beats(20);  // Frame a done, transmitter now halted
                @(negedge clk);
                tx_lfc_req = 1'b1;
                wait_tx_beats(20 + `MCF_BEATS);
                @(negedge clk);
                tx_lfc_req = 1'b0;
            end
        join
        for (int i = 0; i < 20; i++) compare_app_beat("coupling frame a", last_a);
        if (rise_cyc >= last_a) abort_run("Receive pause did not arrive during the frame");
        expect_pause_frame("coupling xoff", CFG_QUANTA, s_off);
        expect_pause_frame("coupling xon", 16'd0, s_on);
        if (s_off >= fall_cyc) abort_run("PAUSE frame was not sent while paused");
        compare_app_beat("coupling frame b", stamp);
        if (stamp < fall_cyc) abort_run("New frame started before the pause ended");
        for (int i = 0; i < 2; i++) compare_app_beat("coupling frame b", stamp);
        check_eq("coupling pause ack", 1, ack_seen);
        @(negedge clk);
        tx_lfc_pause_en = 1'b0;
    endtask

    initial begin
        arst_n = 1'b0;
        app_tx_tdata = '0;
        app_tx_tkeep = '0;
        app_tx_tvalid = 1'b0;
        app_tx_tlast = 1'b0;
        mac_tx_tready = 1'b1;
        mac_rx_tdata = '0;
        mac_rx_tkeep = '0;
        mac_rx_tvalid = 1'b0;
        mac_rx_tlast = 1'b0;
        mac_rx_tuser = 1'b0;
        tx_lfc_req = 1'b0;
        tx_lfc_resend = 1'b0;
        rx_lfc_en = 1'b1;
        rx_lfc_ack = 1'b0;
        tx_lfc_pause_en = 1'b0;
        tx_pause_req = 1'b0;
        cfg_tx_lfc_en = 1'b1;
        cfg_tx_lfc_src = CFG_SRC;
        cfg_tx_lfc_quanta = CFG_QUANTA;
        cfg_tx_lfc_refresh = CFG_REFR;
        cfg_rx_lfc_en = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_tx_passthrough();
        test_rx_filter();
        test_pause_gen();
        test_rx_timer();
        test_pause_coupling();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
eth_lfc_pkg.sv
mac_ctrl_tx.sv
mac_pause_ctrl_tx.sv
mac_ctrl_rx.sv
mac_pause_ctrl_rx.sv
eth_mac_lfc.sv
tb_eth_mac_lfc.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_eth_mac_lfc -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
